// File: design/core_pkg.sv
`default_nettype none

package core_pkg;

  ////////////////////////////////////////////////////////////
  // widths and vector types
  ////////////////////////////////////////////////////////////
  localparam int xlen       = 32;  // integer data path
  localparam int reg_addr_w = 5;   // x0..x31

  typedef logic [xlen-1:0]       word_t;      // register / alu data
  typedef logic [reg_addr_w-1:0] reg_addr_t;  // register index
  typedef logic [31:0]           instr_t;     // raw instruction word
  typedef logic [6:0]            opcode_t;    // major opcode, bits 6:0
  typedef logic [2:0]            funct3_t;    // bits 14:12
  typedef logic [6:0]            funct7_t;    // bits 31:25

  ////////////////////////////////////////////////////////////
  // opcodes and funct7 values
  ////////////////////////////////////////////////////////////
  localparam opcode_t op_imm = 7'b0010011;  // addi, slti, ... srai
  localparam opcode_t op_reg = 7'b0110011;  // add, sub, ... and
  localparam opcode_t op_lui = 7'b0110111;  // lui

  localparam funct7_t f7_base = 7'b0000000;  // normal encoding
  localparam funct7_t f7_alt  = 7'b0100000;  // sub and sra only

  ////////////////////////////////////////////////////////////
  // alu operations
  ////////////////////////////////////////////////////////////
  typedef enum logic [3:0] {
    alu_add    = 4'd0,
    alu_sub    = 4'd1,
    alu_sll    = 4'd2,
    alu_slt    = 4'd3,   // signed compare
    alu_sltu   = 4'd4,   // unsigned compare
    alu_xor    = 4'd5,
    alu_srl    = 4'd6,
    alu_sra    = 4'd7,   // sign fill
    alu_or     = 4'd8,
    alu_and    = 4'd9,
    alu_pass_b = 4'd10   // lui, b carries the u immediate
  } alu_op_e;

endpackage

`default_nettype wire

// File: design/reg_file.sv
`timescale 1ns/10ps
`default_nettype none

module reg_file (
  input  wire                      clk,
  input  wire core_pkg::reg_addr_t rs1_addr,  // read port 0 address
  input  wire core_pkg::reg_addr_t rs2_addr,  // read port 1 address
  output core_pkg::word_t          rs1_data,  // read port 0 data
  output core_pkg::word_t          rs2_data,  // read port 1 data
  input  wire                      we,        // write enable
  input  wire core_pkg::reg_addr_t wr_addr,   // write address
  input  wire core_pkg::word_t     wr_data    // write data
);

  import core_pkg::*;

  ////////////////////////////////////////////////////////////
  // storage
  ////////////////////////////////////////////////////////////
  // 32 words of 32 bits, contents undefined after power up
  word_t mem [2**reg_addr_w];

  // raw array reads, before the x0 override
  word_t rd_raw_1;
  word_t rd_raw_2;

  ////////////////////////////////////////////////////////////
  // write port
  ////////////////////////////////////////////////////////////
  // falling edge write, so a value written back in one cycle
  // is seen by a combinational read in the second half of it
  always_ff @(negedge clk) begin
    if (we) begin
      mem[wr_addr] <= wr_data;  // x0 slot may be written, never read
    end
  end

  ////////////////////////////////////////////////////////////
  // read ports
  ////////////////////////////////////////////////////////////
  assign rd_raw_1 = mem[rs1_addr];  // async read
  assign rd_raw_2 = mem[rs2_addr];

  // x0 is hardwired to zero whatever the array holds
  always_comb begin
    if (rs1_addr == '0) begin
      rs1_data = '0;
    end else begin
      rs1_data = rd_raw_1;
    end
  end

  always_comb begin
    if (rs2_addr == '0) begin
      rs2_data = '0;
    end else begin
      rs2_data = rd_raw_2;
    end
  end

endmodule

`default_nettype wire

// File: design/instr_decode.sv
`timescale 1ns/10ps
`default_nettype none

module instr_decode (
  input  wire                      clk,
  input  wire                      arst_n,
  input  wire                      instr_valid,  // one word per cycle
  input  wire core_pkg::instr_t    instr,
  output core_pkg::reg_addr_t      rs1_addr,     // to reg file
  output core_pkg::reg_addr_t      rs2_addr,
  input  wire core_pkg::word_t     rs1_data,     // from reg file
  input  wire core_pkg::word_t     rs2_data,
  input  wire core_pkg::word_t     alu_result,   // stage two result, bypass
  output logic                     ex_valid,
  output core_pkg::alu_op_e        ex_op,
  output core_pkg::word_t          ex_a,
  output core_pkg::word_t          ex_b,
  output core_pkg::reg_addr_t      ex_rd,
  output logic                     illegal       // one cycle pulse
);

  import core_pkg::*;

  // instruction fields
  opcode_t   opcode;
  funct3_t   funct3;
  funct7_t   funct7;
  reg_addr_t rd;
  word_t     imm_i;   // sign extended 12 bit immediate
  word_t     imm_u;   // upper 20 bits, low 12 zero
  word_t     imm;

  // decode results
  alu_op_e   op_dec;
  logic      legal;
  logic      use_imm;  // operand b from immediate

  // operand select
  logic      fwd_a;
  logic      fwd_b;
  word_t     opnd_a;
  word_t     opnd_b;

  ////////////////////////////////////////////////////////////
  // field split
  ////////////////////////////////////////////////////////////
  assign opcode   = instr[6:0];
  assign rd       = instr[11:7];
  assign funct3   = instr[14:12];
  assign rs1_addr = instr[19:15];
  assign rs2_addr = instr[24:20];
  assign funct7   = instr[31:25];

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_u = {instr[31:12], 12'h000};
  assign imm   = (opcode == op_lui) ? imm_u : imm_i;

  ////////////////////////////////////////////////////////////
  // opcode / funct decode
  ////////////////////////////////////////////////////////////
  always_comb begin
    op_dec  = alu_add;
    legal   = 1'b0;  // anything not matched below is illegal
    use_imm = 1'b0;
    case (opcode)
      op_reg: begin
        case (funct3)
          3'b000: op_dec = (funct7 == f7_alt) ? alu_sub : alu_add;
          3'b001: op_dec = alu_sll;
          3'b010: op_dec = alu_slt;
          3'b011: op_dec = alu_sltu;
          3'b100: op_dec = alu_xor;
          3'b101: op_dec = (funct7 == f7_alt) ? alu_sra : alu_srl;
          3'b110: op_dec = alu_or;
          default: op_dec = alu_and;
        endcase
        // alternate funct7 only valid for sub and sra
        legal = (funct7 == f7_base) ||
                ((funct7 == f7_alt) && ((funct3 == 3'b000) || (funct3 == 3'b101)));
      end
      op_imm: begin
        use_imm = 1'b1;
        legal   = 1'b1;
        case (funct3)
          3'b000: op_dec = alu_add;
          3'b001: begin
            op_dec = alu_sll;
            legal  = (funct7 == f7_base);  // shamt field upper bits
          end
          3'b010: op_dec = alu_slt;
          3'b011: op_dec = alu_sltu;
          3'b100: op_dec = alu_xor;
          3'b101: begin
            op_dec = (funct7 == f7_alt) ? alu_sra : alu_srl;
            legal  = (funct7 == f7_base) || (funct7 == f7_alt);
          end
          3'b110: op_dec = alu_or;
          default: op_dec = alu_and;
        endcase
      end
      op_lui: begin
        op_dec  = alu_pass_b;
        use_imm = 1'b1;
        legal   = 1'b1;
      end
      default: legal = 1'b0;  // unknown opcode
    endcase
  end

  ////////////////////////////////////////////////////////////
  // operand select with bypass from stage two
  ////////////////////////////////////////////////////////////
  // ex_valid is never set for rd == x0, so no x0 forwarding
  assign fwd_a = ex_valid && (ex_rd == rs1_addr);
  assign fwd_b = ex_valid && (ex_rd == rs2_addr);

  assign opnd_a = fwd_a ? alu_result : rs1_data;
  assign opnd_b = use_imm ? imm : (fwd_b ? alu_result : rs2_data);

  ////////////////////////////////////////////////////////////
  // stage two registers
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ex_valid <= 1'b0;
      illegal  <= 1'b0;
    end else begin
      ex_valid <= instr_valid && legal && (rd != '0);  // drop x0 writes
      illegal  <= instr_valid && !legal;
    end
  end

  // payload, qualified by ex_valid
  always_ff @(posedge clk) begin
    ex_op <= op_dec;
    ex_a  <= opnd_a;
    ex_b  <= opnd_b;
    ex_rd <= rd;
  end

endmodule

`default_nettype wire

// File: design/alu_stage.sv
`timescale 1ns/10ps
`default_nettype none

module alu_stage (
  input  wire                      clk,
  input  wire                      arst_n,
  input  wire                      ex_valid,    // stage two holds a writer
  input  wire core_pkg::alu_op_e   ex_op,
  input  wire core_pkg::word_t     ex_a,
  input  wire core_pkg::word_t     ex_b,
  input  wire core_pkg::reg_addr_t ex_rd,
  output core_pkg::word_t          alu_result,  // combinational, to bypass
  output logic                     wb_valid,
  output core_pkg::reg_addr_t      wb_addr,
  output core_pkg::word_t          wb_data
);

  import core_pkg::*;

  logic [4:0] shamt;      // shift amount from low bits of b
  logic       lt_signed;
  logic       lt_unsigned;

  ////////////////////////////////////////////////////////////
  // alu
  ////////////////////////////////////////////////////////////
  assign shamt       = ex_b[4:0];
  assign lt_signed   = $signed(ex_a) < $signed(ex_b);
  assign lt_unsigned = ex_a < ex_b;

  always_comb begin
    case (ex_op)
      alu_add:    alu_result = ex_a + ex_b;
      alu_sub:    alu_result = ex_a - ex_b;  // wraps mod 2^32
      alu_sll:    alu_result = ex_a << shamt;
      alu_slt:    alu_result = {{(xlen-1){1'b0}}, lt_signed};
      alu_sltu:   alu_result = {{(xlen-1){1'b0}}, lt_unsigned};
      alu_xor:    alu_result = ex_a ^ ex_b;
      alu_srl:    alu_result = ex_a >> shamt;
      alu_sra:    alu_result = word_t'($signed(ex_a) >>> shamt);  // sign fill
      alu_or:     alu_result = ex_a | ex_b;
      alu_and:    alu_result = ex_a & ex_b;
      alu_pass_b: alu_result = ex_b;         // lui
      default:    alu_result = '0;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // writeback registers
  ////////////////////////////////////////////////////////////
  // one cycle from ex_valid to wb_valid, held for one cycle
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wb_valid <= 1'b0;
    end else begin
      wb_valid <= ex_valid;
    end
  end

  always_ff @(posedge clk) begin
    wb_addr <= ex_rd;       // only meaningful with wb_valid
    wb_data <= alu_result;
  end

endmodule

`default_nettype wire

// File: design/exec_core.sv
`timescale 1ns/10ps
`default_nettype none

module exec_core (
  input  wire                      clk,
  input  wire                      arst_n,
  input  wire                      instr_valid,  // no ready, never stalls
  input  wire core_pkg::instr_t    instr,
  output logic                     wb_valid,     // result, two cycles later
  output core_pkg::reg_addr_t      wb_addr,
  output core_pkg::word_t          wb_data,
  output logic                     illegal       // one cycle after the word
);

  import core_pkg::*;

  // decoder <-> reg file
  reg_addr_t rs1_addr;
  reg_addr_t rs2_addr;
  word_t     rs1_data;
  word_t     rs2_data;

  // decoder -> alu stage
  logic      ex_valid;
  alu_op_e   ex_op;
  word_t     ex_a;
  word_t     ex_b;
  reg_addr_t ex_rd;

  word_t     alu_result;  // alu stage -> decoder bypass

  ////////////////////////////////////////////////////////////
  // stage one, decode and operand read
  ////////////////////////////////////////////////////////////
  instr_decode instr_decode_inst (
    .clk         (clk),
    .arst_n      (arst_n),
    .instr_valid (instr_valid),
    .instr       (instr),
    .rs1_addr    (rs1_addr),
    .rs2_addr    (rs2_addr),
    .rs1_data    (rs1_data),
    .rs2_data    (rs2_data),
    .alu_result  (alu_result),
    .ex_valid    (ex_valid),
    .ex_op       (ex_op),
    .ex_a        (ex_a),
    .ex_b        (ex_b),
    .ex_rd       (ex_rd),
    .illegal     (illegal)
  );

  // write port fed straight from the writeback registers
  reg_file reg_file_inst (
    .clk      (clk),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .we       (wb_valid),
    .wr_addr  (wb_addr),
    .wr_data  (wb_data)
  );

  ////////////////////////////////////////////////////////////
  // stage two, execute and writeback
  ////////////////////////////////////////////////////////////
  alu_stage alu_stage_inst (
    .clk        (clk),
    .arst_n     (arst_n),
    .ex_valid   (ex_valid),
    .ex_op      (ex_op),
    .ex_a       (ex_a),
    .ex_b       (ex_b),
    .ex_rd      (ex_rd),
    .alu_result (alu_result),
    .wb_valid   (wb_valid),
    .wb_addr    (wb_addr),
    .wb_data    (wb_data)
  );

endmodule

`default_nettype wire

// File: sim/exec_checker.sv
`timescale 1ns/10ps
`default_nettype none

module exec_checker (
  input  wire                      clk,
  input  wire                      arst_n,
  input  wire                      wb_valid,   // dut writeback port
  input  wire core_pkg::reg_addr_t wb_addr,
  input  wire core_pkg::word_t     wb_data,
  input  wire                      illegal,
  input  wire                      exp_act,    // a table row is being driven
  input  wire                      exp_wb,
  input  wire core_pkg::reg_addr_t exp_rd,
  input  wire core_pkg::word_t     exp_data,
  input  wire                      exp_ill,
  input  wire [15:0]               exp_id,     // row number
  input  wire [31:0]               n_tests,
  output logic                     done,
  output int                       errors
);

  import core_pkg::*;

  typedef struct packed {
    logic        act;
    logic        wb;
    logic        ill;
    reg_addr_t   rd;
    word_t       data;
    logic [15:0] id;
  } exp_rec_t;

  exp_rec_t pipe_1;           // illegal pulse due now
  exp_rec_t pipe_2;           // writeback due now
  logic     ill_seen_1;       // illegal as seen for pipe_1
  logic     ill_seen_2;
  logic     rst_seen = 1'b0;  // reset release already reported
  int       checked  = 0;
  int       passed   = 0;
  int       failed   = 0;
  int       other    = 0;     // reset and stray pulse errors

  assign done   = rst_seen && (checked == n_tests);
  assign errors = failed + other;

  task automatic show_mismatch(input string name, input logic [31:0] got,
                               input logic [31:0] exp, input logic [15:0] id);
    $display("MISMATCH at %0t ns, test %0d, %s: got %h, expected %h",
             $time, id, name, got, exp);
  endtask

  ////////////////////////////////////////////////////////////
  // expected fields delayed along with the pipeline
  ////////////////////////////////////////////////////////////
  always @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pipe_1     <= '0;
      pipe_2     <= '0;
      ill_seen_2 <= 1'b0;
    end else begin
      pipe_1     <= {exp_act, exp_wb, exp_ill, exp_rd, exp_data, exp_id};
      pipe_2     <= pipe_1;
      ill_seen_2 <= ill_seen_1;  // travels with its row
    end
  end

  ////////////////////////////////////////////////////////////
  // compare at the falling edge where outputs have settled
  ////////////////////////////////////////////////////////////
  always @(negedge clk) begin : compare_blk
    int fails;
    fails = 0;
    if (!arst_n) begin
      if ((wb_valid !== 1'b0) || (illegal !== 1'b0)) begin
        $display("reset: wb_valid or illegal not low at %0t ns", $time);
        other++;
      end
    end else begin
      if (!rst_seen) begin
        if (other == 0) $display("test reset passed");
        else $display("test reset failed, outputs were not held low");
        rst_seen = 1'b1;
      end
      if (pipe_1.act) begin
        ill_seen_1 <= illegal;
      end else if (illegal !== 1'b0) begin
        $display("illegal raised at %0t ns with no instruction behind it", $time);
        other++;
      end
      if (pipe_2.act) begin
        if (wb_valid !== pipe_2.wb) begin
          show_mismatch("wb_valid", {31'd0, wb_valid}, {31'd0, pipe_2.wb}, pipe_2.id);
          fails++;
        end
        if (pipe_2.wb && (wb_addr !== pipe_2.rd)) begin
          show_mismatch("wb_addr", {27'd0, wb_addr}, {27'd0, pipe_2.rd}, pipe_2.id);
          fails++;
        end
        if (pipe_2.wb && (wb_data !== pipe_2.data)) begin
          show_mismatch("wb_data", wb_data, pipe_2.data, pipe_2.id);
          fails++;
        end
        if (ill_seen_2 !== pipe_2.ill) begin
          show_mismatch("illegal", {31'd0, ill_seen_2}, {31'd0, pipe_2.ill}, pipe_2.id);
          fails++;
        end
        checked++;
        if (fails == 0) begin
          passed++;
          $display("test %0d passed", pipe_2.id);
        end else begin
          failed++;
        end
        if (checked == n_tests) begin
          $display("checker: %0d tests, %0d passed, %0d failed, %0d other errors",
                   checked, passed, failed, other);
        end
      end else if (wb_valid !== 1'b0) begin
        $display("wb_valid raised at %0t ns with no instruction behind it", $time);
        other++;
      end
    end
  end

endmodule

`default_nettype wire

// File: sim/tb_exec_core.sv
`timescale 1ns/10ps
`default_nettype none

module tb_exec_core;

  import core_pkg::*;

  localparam int clk_period   = 20;
  localparam int reset_cycles = 4;
  localparam int table_len    = 39;  // rows added by build_table
  localparam int margin       = 20;  // watchdog slack in cycles
  localparam int drive_delay  = 1;   // ns after the rising edge

  logic      clk = 1'b0;
  logic      arst_n;
  logic      instr_valid;
  instr_t    instr;
  logic      wb_valid;
  reg_addr_t wb_addr;
  word_t     wb_data;
  logic      illegal;

  // expected fields, driven alongside the instruction
  logic        exp_act;
  logic        exp_wb;
  reg_addr_t   exp_rd;
  word_t       exp_data;
  logic        exp_ill;
  logic [15:0] exp_id;
  logic        chk_done;
  int          chk_errors;

  ////////////////////////////////////////////////////////////
  // stimulus table
  ////////////////////////////////////////////////////////////
  instr_t    tbl_instr [table_len];
  logic      tbl_wb    [table_len];
  reg_addr_t tbl_rd    [table_len];
  word_t     tbl_data  [table_len];
  logic      tbl_ill   [table_len];
  int        n_rows = 0;
  integer    seed;

  always #(clk_period / 2) clk = ~clk;

  exec_core exec_core_inst (
    .clk (clk), .arst_n (arst_n), .instr_valid (instr_valid), .instr (instr),
    .wb_valid (wb_valid), .wb_addr (wb_addr), .wb_data (wb_data), .illegal (illegal)
  );

  exec_checker checker_inst (
    .clk (clk), .arst_n (arst_n), .wb_valid (wb_valid), .wb_addr (wb_addr),
    .wb_data (wb_data), .illegal (illegal), .exp_act (exp_act), .exp_wb (exp_wb),
    .exp_rd (exp_rd), .exp_data (exp_data), .exp_ill (exp_ill), .exp_id (exp_id),
    .n_tests (table_len), .done (chk_done), .errors (chk_errors)
  );

  // encoders for the three formats used here
  function automatic instr_t r_word(input logic [6:0] f7, input reg_addr_t rs2,
                                    input reg_addr_t rs1, input logic [2:0] f3,
                                    input reg_addr_t rd);
    return {f7, rs2, rs1, f3, rd, op_reg};
  endfunction

  function automatic instr_t i_word(input logic [11:0] imm, input reg_addr_t rs1,
                                    input logic [2:0] f3, input reg_addr_t rd);
    return {imm, rs1, f3, rd, op_imm};
  endfunction

  function automatic instr_t u_word(input logic [19:0] imm, input reg_addr_t rd);
    return {imm, rd, op_lui};
  endfunction

  function automatic word_t sext12(input logic [11:0] v);
    return {{20{v[11]}}, v};
  endfunction

  task automatic add_row(input instr_t w, input logic wb, input reg_addr_t rd,
                         input word_t data, input logic ill);
    tbl_instr[n_rows] = w;
    tbl_wb[n_rows]    = wb;
    tbl_rd[n_rows]    = rd;
    tbl_data[n_rows]  = data;
    tbl_ill[n_rows]   = ill;
    n_rows++;
  endtask

  task automatic build_table();
    logic [31:0] rnd;
    logic [11:0] imm_a;
    logic [11:0] imm_b;
    logic [11:0] imm_c;
    logic [19:0] imm_u;
    rnd = $random(seed);
    imm_a = rnd[11:0];
    rnd = $random(seed);
    imm_b = rnd[11:0];
    rnd = $random(seed);
    imm_c = rnd[11:0];
    rnd = $random(seed);
    imm_u = rnd[31:12];
    // register loads from x0
    add_row(i_word(12'h005, 5'd0, 3'b000, 5'd1), 1'b1, 5'd1, 32'h0000_0005, 1'b0);
    add_row(i_word(12'hffd, 5'd0, 3'b000, 5'd2), 1'b1, 5'd2, 32'hffff_fffd, 1'b0);
    add_row(i_word(12'h7ff, 5'd0, 3'b000, 5'd3), 1'b1, 5'd3, 32'h0000_07ff, 1'b0);
    add_row(u_word(20'h80000, 5'd4), 1'b1, 5'd4, 32'h8000_0000, 1'b0);
    add_row(i_word(12'h001, 5'd0, 3'b000, 5'd5), 1'b1, 5'd5, 32'h0000_0001, 1'b0);
    // register-register group
    add_row(r_word(7'h00, 5'd3, 5'd1, 3'b000, 5'd6), 1'b1, 5'd6, 32'h0000_0804, 1'b0);
    add_row(r_word(7'h20, 5'd5, 5'd0, 3'b000, 5'd7), 1'b1, 5'd7, 32'hffff_ffff, 1'b0);
    add_row(r_word(7'h20, 5'd3, 5'd1, 3'b000, 5'd8), 1'b1, 5'd8, 32'hffff_f806, 1'b0);
    add_row(r_word(7'h00, 5'd5, 5'd1, 3'b001, 5'd9), 1'b1, 5'd9, 32'h0000_000a, 1'b0);
    add_row(r_word(7'h00, 5'd1, 5'd2, 3'b010, 5'd10), 1'b1, 5'd10, 32'h0000_0001, 1'b0);
    add_row(r_word(7'h00, 5'd1, 5'd2, 3'b011, 5'd11), 1'b1, 5'd11, 32'h0000_0000, 1'b0);
    add_row(r_word(7'h00, 5'd3, 5'd1, 3'b100, 5'd12), 1'b1, 5'd12, 32'h0000_07fa, 1'b0);
    add_row(r_word(7'h00, 5'd5, 5'd4, 3'b101, 5'd13), 1'b1, 5'd13, 32'h4000_0000, 1'b0);
    add_row(r_word(7'h20, 5'd5, 5'd4, 3'b101, 5'd14), 1'b1, 5'd14, 32'hc000_0000, 1'b0);
    add_row(r_word(7'h00, 5'd4, 5'd1, 3'b110, 5'd15), 1'b1, 5'd15, 32'h8000_0005, 1'b0);
    add_row(r_word(7'h00, 5'd3, 5'd2, 3'b111, 5'd16), 1'b1, 5'd16, 32'h0000_07fd, 1'b0);
    // immediate group
    add_row(i_word(12'hffe, 5'd2, 3'b010, 5'd17), 1'b1, 5'd17, 32'h0000_0001, 1'b0);
    add_row(i_word(12'hfff, 5'd1, 3'b011, 5'd18), 1'b1, 5'd18, 32'h0000_0001, 1'b0);
    add_row(i_word(12'hfff, 5'd2, 3'b100, 5'd19), 1'b1, 5'd19, 32'h0000_0002, 1'b0);
    add_row(i_word(12'h0f0, 5'd1, 3'b110, 5'd20), 1'b1, 5'd20, 32'h0000_00f5, 1'b0);
    add_row(i_word(12'h0f0, 5'd2, 3'b111, 5'd21), 1'b1, 5'd21, 32'h0000_00f0, 1'b0);
    add_row(i_word(12'h004, 5'd1, 3'b001, 5'd22), 1'b1, 5'd22, 32'h0000_0050, 1'b0);
    add_row(i_word(12'h004, 5'd4, 3'b101, 5'd23), 1'b1, 5'd23, 32'h0800_0000, 1'b0);
    add_row(i_word(12'h404, 5'd4, 3'b101, 5'd24), 1'b1, 5'd24, 32'hf800_0000, 1'b0);
    // dependent chain, bypass then falling-edge write
    add_row(i_word(12'h064, 5'd0, 3'b000, 5'd25), 1'b1, 5'd25, 32'h0000_0064, 1'b0);
    add_row(i_word(12'h017, 5'd25, 3'b000, 5'd25), 1'b1, 5'd25, 32'h0000_007b, 1'b0);
    add_row(r_word(7'h00, 5'd25, 5'd25, 3'b000, 5'd26), 1'b1, 5'd26, 32'h0000_00f6, 1'b0);
    add_row(r_word(7'h20, 5'd26, 5'd1, 3'b000, 5'd27), 1'b1, 5'd27, 32'hffff_ff0f, 1'b0);
    add_row(r_word(7'h00, 5'd0, 5'd26, 3'b000, 5'd28), 1'b1, 5'd28, 32'h0000_00f6, 1'b0);
    // x0 as destination and as source
    add_row(i_word(12'h007, 5'd1, 3'b000, 5'd0), 1'b0, 5'd0, 32'h0, 1'b0);
    add_row(r_word(7'h00, 5'd0, 5'd0, 3'b000, 5'd29), 1'b1, 5'd29, 32'h0000_0000, 1'b0);
    // illegal words aimed at x1, then x1 read back
    add_row({7'h00, 5'd3, 5'd3, 3'b000, 5'd1, 7'b1111111}, 1'b0, 5'd0, 32'h0, 1'b1);
    add_row(r_word(7'h01, 5'd3, 5'd3, 3'b000, 5'd1), 1'b0, 5'd0, 32'h0, 1'b1);
    add_row(i_word(12'h401, 5'd3, 3'b001, 5'd1), 1'b0, 5'd0, 32'h0, 1'b1);
    add_row(i_word(12'h000, 5'd1, 3'b000, 5'd30), 1'b1, 5'd30, 32'h0000_0005, 1'b0);
    // random immediates
    add_row(i_word(imm_a, 5'd0, 3'b000, 5'd31), 1'b1, 5'd31, sext12(imm_a), 1'b0);
    add_row(i_word(imm_b, 5'd31, 3'b100, 5'd30), 1'b1, 5'd30,
            sext12(imm_a) ^ sext12(imm_b), 1'b0);
    add_row(i_word(imm_c, 5'd31, 3'b000, 5'd29), 1'b1, 5'd29,
            sext12(imm_a) + sext12(imm_c), 1'b0);
    add_row(u_word(imm_u, 5'd28), 1'b1, 5'd28, {imm_u, 12'h000}, 1'b0);
  endtask

  ////////////////////////////////////////////////////////////
  // reset, driving loop and verdict
  ////////////////////////////////////////////////////////////
  initial begin
    seed        = 32'hf6e9_c779;
    arst_n      = 1'b0;
    instr_valid = 1'b0;
    instr       = '0;
    exp_act     = 1'b0;
    exp_wb      = 1'b0;
    exp_rd      = '0;
    exp_data    = '0;
    exp_ill     = 1'b0;
    exp_id      = '0;
    build_table();
    repeat (reset_cycles) @(posedge clk);
    #drive_delay;
    arst_n = 1'b1;
    for (int i = 0; i < n_rows; i++) begin
      @(posedge clk);
      #drive_delay;
      instr_valid = 1'b1;
      instr       = tbl_instr[i];
      exp_act     = 1'b1;       // checker takes it at the same edge as the dut
      exp_wb      = tbl_wb[i];
      exp_rd      = tbl_rd[i];
      exp_data    = tbl_data[i];
      exp_ill     = tbl_ill[i];
      exp_id      = 16'(i);
    end
    @(posedge clk);
    #drive_delay;
    instr_valid = 1'b0;
    exp_act     = 1'b0;
    wait (chk_done === 1'b1);
    repeat (2) @(posedge clk);  // idle cycles still watched for stray pulses
    if (chk_errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(clk_period * (reset_cycles + table_len + margin));
    $display("timeout: the checker did not finish all %0d tests in time", table_len);
    $display("Regression failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: exec_core.f
design/core_pkg.sv
design/reg_file.sv
design/instr_decode.sv
design/alu_stage.sv
design/exec_core.sv
sim/exec_checker.sv
sim/tb_exec_core.sv

// File: run_sim.sh
#!/usr/bin/env bash
# compile the exec_core testbench with verilator, run it, and grade the log

cd "$(dirname "$0")" || exit 1

build_log=build.log
run_log=sim.log

rm -rf obj_dir

verilator --binary --timing --timescale 1ns/10ps \
  --top-module tb_exec_core -f exec_core.f -o tb_exec_core > "$build_log" 2>&1 \
  && ./obj_dir/tb_exec_core > "$run_log" 2>&1 \
  || { echo "build or run failed, see $build_log and $run_log"; exit 1; }

cat "$run_log"

grep -q "^Regression passed$" "$run_log" \
  && { echo "simulation result: PASS"; exit 0; } \
  || { echo "simulation result: FAIL"; exit 1; }
